// ==== Bender.yml ====
package:
  name: wide_add

sources:
  - files:
      - design/wide_add_pkg.sv
      - design/ks_block8.sv
      - design/ks_adder64.sv
      - design/limb_datapath.sv
      - design/limb_counter.sv
      - design/limb_fsm.sv
      - design/wide_add_unit.sv
  - target: test
    files:
      - verification/wide_add_checker.sv
      - verification/tb_wide_add.sv

// ==== design/ks_adder64.sv ====
`timescale 1ns/100ps
`default_nettype none

module ks_adder64 (
  input  logic [wide_add_pkg::LIMB_W-1:0] a,
  input  logic [wide_add_pkg::LIMB_W-1:0] b,
  input  logic                            cin,
  output logic [wide_add_pkg::LIMB_W-1:0] sum,
  output logic                            cout
);
  import wide_add_pkg::*;

  localparam int NUM_BLOCKS = LIMB_W / BLOCK_W;

  logic [NUM_BLOCKS:0] carry;  // carry[k] enters block k

  assign carry[0] = cin;

  // Block carries ripple from the low byte up
  for (genvar k = 0; k < NUM_BLOCKS; k++) begin : g_block
    ks_block8 block_i (
      .a    (a[k*BLOCK_W +: BLOCK_W]),
      .b    (b[k*BLOCK_W +: BLOCK_W]),
      .cin  (carry[k]),
      .sum  (sum[k*BLOCK_W +: BLOCK_W]),
      .cout (carry[k+1])
    );
  end

  assign cout = carry[NUM_BLOCKS];

endmodule

`default_nettype wire

// ==== design/ks_block8.sv ====
`timescale 1ns/100ps
`default_nettype none

module ks_block8 (
  input  logic [wide_add_pkg::BLOCK_W-1:0] a,
  input  logic [wide_add_pkg::BLOCK_W-1:0] b,
  input  logic                             cin,
  output logic [wide_add_pkg::BLOCK_W-1:0] sum,
  output logic                             cout
);
  import wide_add_pkg::*;

  logic [BLOCK_W-1:0] p;      // Per-bit propagate
  logic [BLOCK_W-1:0] g;      // Per-bit generate
  logic               g2;     // Group generate over bits 1..0
  logic               p2;     // Group propagate over bits 1..0
  logic [BLOCK_W-3:0] g3;     // Group generate, 3-bit windows
  logic [BLOCK_W-3:0] p3;     // Group propagate, 3-bit windows
  logic [BLOCK_W-1:0] c;      // c[i] is carry out of bit i

  assign p = a ^ b;
  assign g = a & b;

  assign g2 = g[1] | (p[1] & g[0]);
  assign p2 = p[1] & p[0];

  // Window i covers bits i+2 down to i
  assign g3 = g[BLOCK_W-1:2]
            | (p[BLOCK_W-1:2] & g[BLOCK_W-2:1])
            | (p[BLOCK_W-1:2] & p[BLOCK_W-2:1] & g[BLOCK_W-3:0]);
  assign p3 = p[BLOCK_W-1:2] & p[BLOCK_W-2:1] & p[BLOCK_W-3:0];

  // First two carries straight from cin
  assign c[0] = g[0] | (p[0] & cin);
  assign c[1] = g2 | (p2 & cin);

  // Odd and even carries chained two apart
  // p[i] & c[i] collapses to p[i] & carry-in of bit i, so the 3-bit window is exact
  for (genvar i = 2; i < BLOCK_W; i++) begin : g_carry
    assign c[i] = g3[i-2] | (p3[i-2] & c[i-2]);
  end

  assign cout = c[BLOCK_W-1];
  assign sum  = p ^ {c[BLOCK_W-2:0], cin};

endmodule

`default_nettype wire

// ==== design/limb_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module limb_counter #(
  parameter int NUM_WORDS = 4
) (
  input  logic clk,
  input  logic arst_n,
  input  logic clear,
  input  logic accept,
  output logic last
);

  localparam int CNT_W = $clog2(NUM_WORDS + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (accept) begin
      count <= count + 1'b1;
    end
  end

  // Accept during last is the final limb
  assign last = (count == CNT_W'(NUM_WORDS - 1));

endmodule

`default_nettype wire

// ==== design/limb_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module limb_datapath (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    accept,
  input  logic                    first,
  input  logic                    sub,
  input  wide_add_pkg::limb_in_t  limb_in,
  output logic                    out_valid,
  output wide_add_pkg::limb_out_t limb_out
);
  import wide_add_pkg::*;

  logic [LIMB_W-1:0] b_eff;
  logic [LIMB_W-1:0] sum;
  logic              cin;
  logic              cout;
  logic              carry_q;  // Carry between limbs

  // Subtract as a + ~b + 1 over the whole word
  assign b_eff = sub ? ~limb_in.b : limb_in.b;
  assign cin   = first ? sub : carry_q;

  ks_adder64 adder_i (
    .a    (limb_in.a),
    .b    (b_eff),
    .cin  (cin),
    .sum  (sum),
    .cout (cout)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      carry_q   <= 1'b0;
    end else begin
      out_valid <= accept;
      if (accept) begin
        carry_q <= cout;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      limb_out.sum   <= sum;
      limb_out.carry <= cout;  // Means no borrow on subtract
    end
  end

endmodule

`default_nettype wire

// ==== design/limb_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module limb_fsm (
  input  logic clk,
  input  logic arst_n,
  input  logic start,
  input  logic sub,
  input  logic in_valid,
  input  logic last,
  output logic accept,
  output logic first,
  output logic clear,
  output logic sub_latched,
  output logic done,
  output logic busy
);
  import wide_add_pkg::*;

  add_state_t state;
  logic       first_pending;

  assign accept = in_valid && (state == RUN);  // Strobes outside RUN dropped
  assign first  = accept && first_pending;
  assign clear  = start && (state == IDLE);
  assign done   = (state == FINISH);
  assign busy   = (state != IDLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= IDLE;
      first_pending <= 1'b0;
      sub_latched   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state         <= RUN;
            sub_latched   <= sub;
            first_pending <= 1'b1;
          end
        end
        RUN: begin
          if (accept) begin
            first_pending <= 1'b0;
          end
          if (accept && last) begin
            state <= FINISH;
          end
        end
        FINISH: state <= IDLE;  // done lines up with last out_valid
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/wide_add_pkg.sv ====
`default_nettype none

package wide_add_pkg;

  // Limb and adder widths
  parameter int LIMB_W  = 64;
  parameter int BLOCK_W = 8;

  // One operand limb pair
  typedef struct packed {
    logic [LIMB_W-1:0] a;
    logic [LIMB_W-1:0] b;
  } limb_in_t;

  // Registered per-limb result
  typedef struct packed {
    logic [LIMB_W-1:0] sum;
    logic              carry;  // Carry out of this limb
  } limb_out_t;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    RUN    = 2'd1,
    FINISH = 2'd2
  } add_state_t;

endpackage

`default_nettype wire

// ==== design/wide_add_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module wide_add_unit #(
  parameter int NUM_WORDS = 4
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    start,
  input  logic                    sub,
  input  logic                    in_valid,
  input  wide_add_pkg::limb_in_t  limb_in,
  output logic                    out_valid,
  output wide_add_pkg::limb_out_t limb_out,
  output logic                    done,
  output logic                    busy
);

  logic accept;
  logic first;
  logic clear;
  logic sub_latched;
  logic last;

  limb_fsm fsm_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .sub         (sub),
    .in_valid    (in_valid),
    .last        (last),
    .accept      (accept),
    .first       (first),
    .clear       (clear),
    .sub_latched (sub_latched),
    .done        (done),
    .busy        (busy)
  );

  limb_counter #(
    .NUM_WORDS (NUM_WORDS)
  ) counter_i (
    .clk    (clk),
    .arst_n (arst_n),
    .clear  (clear),
    .accept (accept),
    .last   (last)
  );

  limb_datapath datapath_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .accept    (accept),
    .first     (first),
    .sub       (sub_latched),
    .limb_in   (limb_in),
    .out_valid (out_valid),
    .limb_out  (limb_out)
  );

endmodule

`default_nettype wire

// ==== project.f ====
design/wide_add_pkg.sv
design/ks_block8.sv
design/ks_adder64.sv
design/limb_datapath.sv
design/limb_counter.sv
design/limb_fsm.sv
design/wide_add_unit.sv
verification/wide_add_checker.sv
verification/tb_wide_add.sv

// ==== verification/tb_wide_add.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_wide_add;
  import wide_add_pkg::*;

  localparam int NUM_WORDS  = 4;
  localparam int NUM_OPS    = 60;
  localparam int BUSY_LIMIT = 8;
  localparam int DONE_LIMIT = 12;

  logic        clk;
  logic        arst_n;
  logic        start;
  logic        sub;
  logic        in_valid;
  limb_in_t    limb_in;
  logic        out_valid;
  limb_out_t   limb_out;
  logic        done;
  logic        busy;
  logic [63:0] rng;
  int          checks;
  int          errors;
  int          timeouts;
  int          ops_done;
  logic        aborted;

  wide_add_unit #(
    .NUM_WORDS (NUM_WORDS)
  ) dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .sub       (sub),
    .in_valid  (in_valid),
    .limb_in   (limb_in),
    .out_valid (out_valid),
    .limb_out  (limb_out),
    .done      (done),
    .busy      (busy)
  );

  wide_add_checker #(
    .NUM_WORDS (NUM_WORDS)
  ) checker_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .sub       (sub),
    .in_valid  (in_valid),
    .limb_in   (limb_in),
    .out_valid (out_valid),
    .limb_out  (limb_out),
    .done      (done),
    .busy      (busy),
    .checks    (checks),
    .errors    (errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [63:0] xorshift64(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  function automatic logic [63:0] next_rand();
    rng = xorshift64(rng);
    return rng;
  endfunction

  function automatic limb_in_t junk_limb();
    limb_in_t l;
    l.a = next_rand();
    l.b = next_rand();
    return l;
  endfunction

  // Ones and zeros give carry and borrow chains through every block
  function automatic logic [63:0] pick_operand(input logic [1:0] kind, input logic [63:0] r);
    case (kind)
      2'd0: return '1;
      2'd1: return '0;
      2'd2: return 64'd1;
      default: return r;
    endcase
  endfunction

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (busy !== level && n < BUSY_LIMIT);
    if (busy !== level) begin
      timeouts++;
      aborted = 1'b1;
      $display("Timeout after %0d cycles waiting for busy to become %b", n, level);
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (done !== 1'b1 && n < DONE_LIMIT);
    if (done !== 1'b1) begin
      timeouts++;
      aborted = 1'b1;
      $display("Timeout after %0d cycles waiting for done", n);
    end
  endtask

  task automatic run_operation();
    logic [63:0] r;
    logic        same;
    logic [63:0] op_a;
    logic [63:0] op_b;
    int          gap;
    r    = next_rand();
    same = (r[5:3] == 3'd0);  // Equal operands now and then
    @(posedge clk);
    start    <= 1'b1;
    sub      <= r[0];
    in_valid <= r[1];  // Dropped while idle
    limb_in  <= junk_limb();
    @(posedge clk);
    start    <= 1'b0;
    sub      <= r[2];
    in_valid <= 1'b0;
    wait_busy(1'b1);
    if (aborted) begin
      return;
    end
    for (int w = 0; w < NUM_WORDS; w++) begin
      r    = next_rand();
      gap  = r[1:0];
      op_a = pick_operand(r[3:2], next_rand());
      op_b = same ? op_a : pick_operand(r[5:4], next_rand());
      repeat (gap) begin
        @(posedge clk);
        in_valid <= 1'b0;
        start    <= r[6];  // Start while busy must be ignored
        sub      <= r[7];
        limb_in  <= junk_limb();
      end
      @(posedge clk);
      start    <= 1'b0;
      in_valid <= 1'b1;
      limb_in  <= '{a: op_a, b: op_b};
    end
    r = next_rand();
    @(posedge clk);
    in_valid <= r[0];  // Lands in the done cycle
    limb_in  <= junk_limb();
    wait_done();
    if (aborted) begin
      return;
    end
    @(posedge clk);
    in_valid <= 1'b0;
    wait_busy(1'b0);
    if (aborted) begin
      return;
    end
    ops_done++;
  endtask

  initial begin
    rng      = 64'd82259;
    arst_n   = 1'b0;
    start    = 1'b0;
    sub      = 1'b0;
    in_valid = 1'b0;
    limb_in  = '0;
    timeouts = 0;
    ops_done = 0;
    aborted  = 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < NUM_OPS && !aborted; i++) begin
      run_operation();
    end
    repeat (3) @(posedge clk);
    $display("Operations: %0d of %0d, checks: %0d, errors: %0d, timeouts: %0d",
             ops_done, NUM_OPS, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0 && ops_done == NUM_OPS) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/wide_add_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module wide_add_checker #(
  parameter int NUM_WORDS = 4
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    start,
  input  logic                    sub,
  input  logic                    in_valid,
  input  wide_add_pkg::limb_in_t  limb_in,
  input  logic                    out_valid,
  input  wide_add_pkg::limb_out_t limb_out,
  input  logic                    done,
  input  logic                    busy,
  output int                      checks,
  output int                      errors
);
  import wide_add_pkg::*;

  add_state_t        m_state;   // Expected engine state
  logic              m_sub;
  logic              m_carry;   // Running carry of the model
  int                m_count;
  logic              exp_valid;
  logic              exp_done;
  logic              exp_busy;
  logic [LIMB_W-1:0] exp_sum;
  logic              exp_carry;
  logic [LIMB_W-1:0] a_hist [NUM_WORDS];
  logic [LIMB_W-1:0] b_hist [NUM_WORDS];

  initial begin
    checks = 0;
    errors = 0;
  end

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic compare_word(input string name, input logic [LIMB_W-1:0] expected,
                              input logic [LIMB_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // Whole multi-limb a against whole b from the top limb down
  function automatic logic a_not_below_b();
    for (int w = NUM_WORDS - 1; w >= 0; w--) begin
      if (a_hist[w] > b_hist[w]) begin
        return 1'b1;
      end
      if (a_hist[w] < b_hist[w]) begin
        return 1'b0;
      end
    end
    return 1'b1;  // Equal operands give no borrow
  endfunction

  always @(posedge clk) begin
    logic [LIMB_W-1:0] b_eff;
    logic [LIMB_W:0]   full;
    if (!arst_n) begin
      m_state   = IDLE;
      m_sub     = 1'b0;
      m_carry   = 1'b0;
      m_count   = 0;
      exp_valid = 1'b0;
      exp_done  = 1'b0;
      exp_busy  = 1'b0;
    end else begin
      // Outputs of the cycle that just ended
      compare_bit("out_valid", exp_valid, out_valid);
      compare_bit("done", exp_done, done);
      compare_bit("busy", exp_busy, busy);
      if (exp_valid && out_valid) begin
        compare_word("limb_out.sum", exp_sum, limb_out.sum);
        compare_bit("limb_out.carry", exp_carry, limb_out.carry);
      end
      if (exp_done && m_sub) begin
        compare_bit("limb_out.carry (no borrow)", a_not_below_b(), limb_out.carry);
      end

      exp_valid = 1'b0;
      case (m_state)
        IDLE: begin
          if (start) begin
            m_state = RUN;
            m_sub   = sub;
            m_carry = sub;  // Subtract starts with carry in of one
            m_count = 0;
          end
        end
        RUN: begin
          if (in_valid) begin
            b_eff     = m_sub ? ~limb_in.b : limb_in.b;
            full      = {1'b0, limb_in.a} + {1'b0, b_eff} + m_carry;
            exp_sum   = full[LIMB_W-1:0];
            exp_carry = full[LIMB_W];
            m_carry   = full[LIMB_W];
            exp_valid = 1'b1;
            a_hist[m_count] = limb_in.a;
            b_hist[m_count] = limb_in.b;
            m_count++;
            if (m_count == NUM_WORDS) begin
              m_state = FINISH;
            end
          end
        end
        default: m_state = IDLE;
      endcase
      exp_done = (m_state == FINISH);
      exp_busy = (m_state != IDLE);
    end
  end

endmodule

`default_nettype wire
